//--- bench/branch_props.sv
module branch_props (
    input logic        clk,
    input logic        rst,
    input logic        issue_valid,
    input logic        resolve_valid,
    input logic        resolve_ready,
    input logic        resolve_taken,
    input logic [31:0] resolve_target,
    input logic [31:0] resolve_link,
    input logic        resolve_mispredict,
    input logic [31:0] resolve_redirect_pc,
    input logic        resolve_misaligned
);

    timeunit 1ns;
    timeprecision 1ps;

    // reset empties the resolve register by the next edge
    reset_clears_valid: assert property (@(posedge clk) rst |=> !resolve_valid)
        else $error("resolve_valid high in the cycle after reset");

    // a stalled result keeps every field until downstream takes it
    held_result_stable: assert property (@(posedge clk) disable iff (rst)
        resolve_valid && !resolve_ready |=> resolve_valid && $stable(resolve_taken) &&
            $stable(resolve_target) && $stable(resolve_link) &&
            $stable(resolve_mispredict) && $stable(resolve_redirect_pc) &&
            $stable(resolve_misaligned))
        else $error("resolve outputs moved under back-pressure");

    // an empty register takes an offered operation at the next edge
    empty_slot_accepts: assert property (@(posedge clk) disable iff (rst)
        !resolve_valid && issue_valid |=> resolve_valid)
        else $error("operation offered to an empty register was not taken");

endmodule

//--- bench/branch_tb.sv
module branch_tb import branch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PREDICTOR_ENTRIES = 64;
    localparam int TIMEOUT_CYCLES    = 20;

    // one expected result and what the predictor learns from it
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
        logic [31:0] link;
        logic        mispredict;
        logic [31:0] redirect_pc;
        logic        misaligned;
        logic        conditional;
        logic [31:0] pc;
    } expected_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        issue_valid;
    logic        issue_ready;
    branch_op_t  issue_op;
    logic [31:0] issue_rs1;
    logic [31:0] issue_rs2;
    logic [31:0] issue_pc;
    logic [31:0] issue_imm;
    logic        issue_predicted_taken;
    logic        resolve_valid;
    logic        resolve_ready;
    logic        resolve_taken;
    logic [31:0] resolve_target;
    logic [31:0] resolve_link;
    logic        resolve_mispredict;
    logic [31:0] resolve_redirect_pc;
    logic        resolve_misaligned;
    logic [31:0] fetch_pc;
    logic        fetch_predict_taken;

    // model state
    expected_t      expected_q [$];
    expected_t      pending;
    counter_state_t model_counters [PREDICTOR_ENTRIES];
    logic           sampled_issue_ready;
    logic           last_accepted;
    int             error_count = 0;
    int             check_count = 0;
    int             test_count  = 0;

    always #50 clk = ~clk;

    branch_top #(.PREDICTOR_ENTRIES(PREDICTOR_ENTRIES)) DUT (.*);

    bind branch_unit branch_props props (
        .clk                 (clk),
        .rst                 (rst),
        .issue_valid         (issue_valid),
        .resolve_valid       (resolve_valid),
        .resolve_ready       (resolve_ready),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_link        (resolve_link),
        .resolve_mispredict  (resolve_mispredict),
        .resolve_redirect_pc (resolve_redirect_pc),
        .resolve_misaligned  (resolve_misaligned)
    );

    ////////////////////
    // reference model
    ////////////////////
    function automatic logic model_taken(input branch_op_t op, input logic [31:0] a,
                                         input logic [31:0] b);
        case (op)
            branch_eq:  return a == b;
            branch_ne:  return a != b;
            branch_lt:  return $signed(a) < $signed(b);
            branch_ge:  return $signed(a) >= $signed(b);
            branch_ltu: return a < b;
            branch_geu: return a >= b;
            // jumps always leave the fall-through path
            default:    return 1'b1;
        endcase
    endfunction

    function automatic expected_t model_result(input branch_op_t op, input logic [31:0] rs1,
                                               input logic [31:0] rs2, input logic [31:0] pc,
                                               input logic [31:0] imm, input logic predicted);
        expected_t r;
        r.taken = model_taken(op, rs1, rs2);
        if (op == jump_jalr) begin
            r.target = (rs1 + imm) & ~32'd1;
        end else begin
            r.target = pc + imm;
        end
        r.link        = pc + 32'd4;
        r.misaligned  = r.target[1];
        r.mispredict  = r.taken != predicted;
        r.redirect_pc = r.taken ? r.target : r.link;
        r.conditional = (op != jump_jal) && (op != jump_jalr);
        r.pc          = pc;
        return r;
    endfunction

    // word pc bits pick the counter
    function automatic int index_of(input logic [31:0] pc);
        return int'(pc[31:2]) % PREDICTOR_ENTRIES;
    endfunction

    ////////////////////
    // checking
    ////////////////////
    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("timeout: %s", reason);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        test_count++;
        $display("test %s done, %0d errors", name, error_count - start_errors);
    endtask

    // oldest outstanding result must sit on the resolve port
    task automatic compare_head();
        expected_t head;
        if (expected_q.size() == 0) begin
            error_count++;
            $display("resolve_valid is high at %0t with no operation outstanding", $time);
        end else begin
            head = expected_q[0];
            compare_value("resolve_taken", resolve_taken, head.taken);
            compare_value("resolve_target", resolve_target, head.target);
            compare_value("resolve_link", resolve_link, head.link);
            compare_value("resolve_mispredict", resolve_mispredict, head.mispredict);
            compare_value("resolve_redirect_pc", resolve_redirect_pc, head.redirect_pc);
            compare_value("resolve_misaligned", resolve_misaligned, head.misaligned);
        end
    endtask

    // a consumed conditional result steps its counter
    task automatic retire_head();
        expected_t head;
        int        idx;
        head = expected_q.pop_front();
        if (head.conditional) begin
            idx = index_of(head.pc);
            if (head.taken && model_counters[idx] != strong_taken) begin
                model_counters[idx] = counter_state_t'(model_counters[idx] + 2'd1);
            end else if (!head.taken && model_counters[idx] != strong_not_taken) begin
                model_counters[idx] = counter_state_t'(model_counters[idx] - 2'd1);
            end
        end
    endtask

    ////////////////////
    // driving
    ////////////////////

    // sample at the falling edge, then book what the rising edge did
    task automatic advance_cycle();
        logic drained;
        @(negedge clk);
        sampled_issue_ready = issue_ready;
        drained             = resolve_valid && resolve_ready;
        last_accepted       = issue_valid && issue_ready;
        if (resolve_valid) begin
            compare_head();
        end
        @(posedge clk);
        if (drained && expected_q.size() > 0) begin
            retire_head();
        end
        if (last_accepted) begin
            expected_q.push_back(pending);
        end
    endtask

    task automatic drive_op(input branch_op_t op, input logic [31:0] rs1,
                            input logic [31:0] rs2, input logic [31:0] pc,
                            input logic [31:0] imm, input logic predicted);
        issue_valid           <= 1'b1;
        issue_op              <= op;
        issue_rs1             <= rs1;
        issue_rs2             <= rs2;
        issue_pc              <= pc;
        issue_imm             <= imm;
        issue_predicted_taken <= predicted;
        pending = model_result(op, rs1, rs2, pc, imm, predicted);
    endtask

    task automatic wait_accept();
        int cycles;
        cycles = 0;
        do begin
            advance_cycle();
            cycles++;
        end while (!last_accepted && cycles < TIMEOUT_CYCLES);
        if (!last_accepted) begin
            abort_run("issue_ready never accepted the operation");
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() > 0 && cycles < TIMEOUT_CYCLES) begin
            advance_cycle();
            cycles++;
        end
        if (expected_q.size() > 0) begin
            abort_run("resolve_valid did not deliver every outstanding result");
        end
    endtask

    task automatic run_one(input branch_op_t op, input logic [31:0] rs1,
                           input logic [31:0] rs2, input logic [31:0] pc,
                           input logic [31:0] imm, input logic predicted);
        resolve_ready <= 1'b1;
        drive_op(op, rs1, rs2, pc, imm, predicted);
        wait_accept();
        issue_valid <= 1'b0;
        wait_drain();
    endtask

    // pc, prediction and a branch-sized even immediate are random
    task automatic run_random(input branch_op_t op, input logic [31:0] rs1,
                              input logic [31:0] rs2);
        run_one(op, rs1, rs2, $urandom() & 32'hffff_fffc,
                ($urandom() & 32'h0000_1ffe) - 32'h0000_1000, 1'($urandom()));
    endtask

    task automatic check_prediction(input logic [31:0] pc);
        counter_state_t state;
        state = model_counters[index_of(pc)];
        fetch_pc <= pc;
        @(negedge clk);
        compare_value("fetch_predict_taken", fetch_predict_taken,
                      (state == weak_taken) || (state == strong_taken));
        @(posedge clk);
    endtask

    task automatic apply_reset();
        rst           <= 1'b1;
        issue_valid   <= 1'b0;
        resolve_ready <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        expected_q.delete();
        foreach (model_counters[i]) begin
            model_counters[i] = weak_not_taken;
        end
    endtask

    ////////////////////
    // tests
    ////////////////////
    task automatic test_conditional();
        branch_op_t  ops [6];
        logic [31:0] edge_a [10];
        logic [31:0] edge_b [10];
        logic [31:0] a;
        int          start_errors;
        start_errors = error_count;
        ops = '{branch_eq, branch_ne, branch_lt, branch_ge, branch_ltu, branch_geu};
        // equal, sign boundary, all-ones vs one, then neighbours in bit 0 and bit 1
        edge_a = '{32'h1234_5678, 32'h8000_0000, 32'h0000_0000, 32'hffff_ffff,
                   32'h0000_0001, 32'h0000_0010, 32'h8000_0001, 32'h0000_0020,
                   32'hffff_fffe, 32'h7fff_fffd};
        edge_b = '{32'h1234_5678, 32'h0000_0000, 32'h8000_0000, 32'h0000_0001,
                   32'hffff_ffff, 32'h0000_0011, 32'h8000_0000, 32'h0000_0022,
                   32'hffff_fffc, 32'h7fff_ffff};
        foreach (ops[i]) begin
            foreach (edge_a[j]) begin
                run_random(ops[i], edge_a[j], edge_b[j]);
            end
            for (int k = 0; k < 12; k++) begin
                a = $urandom();
                // every third pair is equal, so eq and ne see both answers
                run_random(ops[i], a, (k % 3 == 0) ? a : $urandom());
            end
        end
        finish_test("conditional branches", start_errors);
    endtask

    task automatic test_jumps();
        int start_errors;
        start_errors = error_count;
        run_one(jump_jal, 32'h0, 32'h0, 32'h0000_1000, 32'h0000_0100, 1'b1);
        // bit 1 of the target set
        run_one(jump_jal, 32'h0, 32'h0, 32'h0000_1000, 32'h0000_0102, 1'b1);
        // odd sum loses bit 0
        run_one(jump_jalr, 32'h0000_2001, 32'h0, 32'h0000_1000, 32'h0000_0010, 1'b0);
        run_one(jump_jalr, 32'h0000_2000, 32'h0, 32'h0000_1000, 32'h0000_0003, 1'b1);
        // link wraps past the top of memory
        run_one(jump_jalr, 32'h0000_2000, 32'h0, 32'hffff_fffc, 32'hffff_fffc, 1'b1);
        for (int k = 0; k < 6; k++) begin
            run_random((k % 2 == 1) ? jump_jalr : jump_jal, $urandom(), $urandom());
        end
        finish_test("jumps", start_errors);
    endtask

    task automatic test_mispredict();
        int start_errors;
        start_errors = error_count;
        for (int p = 0; p < 2; p++) begin
            run_one(branch_eq, 32'h5, 32'h5, 32'h0000_3000, 32'h0000_0040, 1'(p));
            run_one(branch_eq, 32'h5, 32'h6, 32'h0000_3000, 32'h0000_0040, 1'(p));
            run_one(branch_ltu, 32'h1, 32'h2, 32'h0000_3100, 32'hffff_ff00, 1'(p));
            run_one(jump_jal, 32'h0, 32'h0, 32'h0000_3200, 32'hffff_ff00, 1'(p));
        end
        finish_test("mispredict and redirect", start_errors);
    endtask

    task automatic test_predictor();
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        int          start_errors;
        start_errors = error_count;
        pc_a = 32'h0000_2040;
        // next word lands in the neighbouring counter
        pc_b = pc_a + 32'd4;
        check_prediction(pc_a);
        check_prediction(pc_b);
        // five takens reach the top and saturate there
        repeat (5) begin
            run_one(branch_eq, 32'h7, 32'h7, pc_a, 32'h0000_0020, 1'b0);
            check_prediction(pc_a);
        end
        repeat (5) begin
            run_one(branch_ne, 32'h7, 32'h7, pc_a, 32'h0000_0020, 1'b1);
            check_prediction(pc_a);
        end
        check_prediction(pc_b);
        finish_test("predictor training", start_errors);
    endtask

    task automatic test_backpressure();
        int start_errors;
        start_errors = error_count;
        resolve_ready <= 1'b0;
        drive_op(branch_lt, 32'hffff_fff0, 32'h10, 32'h0000_4000, 32'h0000_0080, 1'b0);
        wait_accept();
        // second op queues behind the stalled result
        drive_op(jump_jal, 32'h0, 32'h0, 32'h0000_4004, 32'h0000_0200, 1'b1);
        repeat (3) begin
            advance_cycle();
            compare_value("issue_ready", sampled_issue_ready, 1'b0);
        end
        resolve_ready <= 1'b1;
        wait_accept();
        // one op per edge while the port drains
        for (int k = 0; k < 8; k++) begin
            drive_op(branch_op_t'($urandom_range(0, 7)), $urandom(), $urandom(),
                     $urandom() & 32'hffff_fffc, $urandom() & 32'h0000_0ffc,
                     1'($urandom()));
            advance_cycle();
            compare_value("issue_ready", sampled_issue_ready, 1'b1);
        end
        issue_valid <= 1'b0;
        wait_drain();
        finish_test("back-pressure", start_errors);
    endtask

    task automatic test_reset();
        int start_errors;
        start_errors = error_count;
        run_one(branch_geu, 32'h9, 32'h3, 32'h0000_2040, 32'h0000_0020, 1'b0);
        run_one(branch_geu, 32'h9, 32'h3, 32'h0000_2040, 32'h0000_0020, 1'b0);
        check_prediction(32'h0000_2040);
        // leave a result stuck in the register
        resolve_ready <= 1'b0;
        drive_op(jump_jalr, 32'h0000_5000, 32'h0, 32'h0000_4400, 32'h0000_0010, 1'b1);
        wait_accept();
        apply_reset();
        // downstream stays stalled, so issue_ready only follows the empty register
        resolve_ready <= 1'b0;
        @(negedge clk);
        compare_value("resolve_valid", resolve_valid, 1'b0);
        compare_value("issue_ready", issue_ready, 1'b1);
        @(posedge clk);
        resolve_ready <= 1'b1;
        check_prediction(32'h0000_2040);
        finish_test("reset", start_errors);
    endtask

    initial begin
        void'($urandom(32'h1dd9));
        issue_op              <= branch_eq;
        issue_rs1             <= 32'h0;
        issue_rs2             <= 32'h0;
        issue_pc              <= 32'h0;
        issue_imm             <= 32'h0;
        issue_predicted_taken <= 1'b0;
        fetch_pc              <= 32'h0;
        apply_reset();
        test_conditional();
        test_jumps();
        test_mispredict();
        test_predictor();
        test_backpressure();
        test_reset();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- branch_unit/branch_comparator.sv
module branch_comparator (
    input  logic        use_signed,
    input  logic        less_than,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic        xor_result,
    output logic        result
);

    // operands widened by one sign or zero bit
    logic [32:0] ext_a;
    logic [32:0] ext_b;

    // upper 31 bits of each operand plus a padding bit on top
    logic [31:0] lt_x;
    logic [31:0] lt_y;
    logic [31:0] eq_bits;

    // pairwise compressed chain, 16 positions
    logic [15:0] lt_gen;
    logic [15:0] lt_gen_or_prop;
    logic [15:0] eq_pair;

    logic        lt_carry_in;
    logic        eq_carry_in;
    logic        carry_in;
    logic [16:0] chain_sum;

    ////////////////////
    // operand prep
    ////////////////////
    assign ext_a = {a[31] & use_signed, a};
    assign ext_b = {b[31] & use_signed, b};

    // less than uses a + ~b + 1, padding 0 and 1 keep the carry
    assign lt_x = {1'b0, ext_a[32:2]};
    assign lt_y = {1'b1, ~ext_b[32:2]};

    // equality marks every bit position where a and b agree
    // the padding position never agrees, so the top pair starts at zero
    assign eq_bits = {1'b0, ~(ext_a[32:2] ^ ext_b[32:2])};

    // the lowest two bits fold into the carry-in of the short chain
    assign lt_carry_in = (ext_a[1] & ~ext_b[1]) |
                         ((ext_a[1] | ~ext_b[1]) & (ext_a[0] | ~ext_b[0]));
    assign eq_carry_in = ~(ext_a[0] ^ ext_b[0]) & ~(ext_a[1] ^ ext_b[1]);
    assign carry_in    = less_than ? lt_carry_in : eq_carry_in;

    ////////////////////
    // compressor
    ////////////////////
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            // pair generates a carry on its own
            lt_gen[i] = (lt_x[2*i+1] & lt_y[2*i+1]) |
                        (lt_x[2*i] & lt_y[2*i] & (lt_x[2*i+1] | lt_y[2*i+1]));
            // pair generates or passes an incoming carry
            lt_gen_or_prop[i] = lt_gen[i] |
                                ((lt_x[2*i] | lt_y[2*i]) & (lt_x[2*i+1] | lt_y[2*i+1]));
            // both bits of the pair agree
            eq_pair[i] = eq_bits[2*i] & eq_bits[2*i+1];
        end
        // flipping the top position gives ne and ge from eq and lt
        lt_gen[15]  = lt_gen[15] ^ xor_result;
        eq_pair[15] = eq_pair[15] ^ xor_result;
    end

    // bit 16 of the sum is the top sum bit, not a carry out
    // eq ripples the carry through a run of agreeing pairs
    assign chain_sum = less_than ? ({lt_gen, carry_in} + {lt_gen_or_prop, carry_in})
                                 : ({eq_pair, carry_in} + {16'h0000, carry_in});

    assign result = chain_sum[16];

endmodule

//--- branch_unit/branch_target.sv
module branch_target import branch_pkg::*; (
    input  branch_op_t  op,
    input  logic [31:0] pc,
    input  logic [31:0] rs1,
    input  logic [31:0] imm,
    output logic [31:0] target,
    output logic [31:0] link,
    output logic        misaligned
);

    logic        reg_relative;
    logic [31:0] base;
    logic [31:0] raw_sum;

    ////////////////////
    // target adder
    ////////////////////

    // only jalr adds to a register, everything else is pc relative
    assign reg_relative = (op == jump_jalr);

    always_comb begin
        if (reg_relative) begin
            base = rs1;
        end else begin
            base = pc;
        end
    end

    // one shared adder for both bases
    assign raw_sum = base + imm;

    // jalr drops bit 0 of the sum
    always_comb begin
        target = raw_sum;
        if (reg_relative) begin
            target[0] = 1'b0;
        end
    end

    ////////////////////
    // link and alignment
    ////////////////////

    // return address of the next 32-bit instruction
    assign link = pc + 32'd4;

    // no compressed instructions, so targets must sit on a word
    // bit 0 is either cleared or already zero from an even immediate
    // only bit 1 can break alignment
    assign misaligned = target[1];

endmodule

//--- branch_unit/branch_unit.sv
module branch_unit import branch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // issue port
    input  logic        issue_valid,
    output logic        issue_ready,
    input  branch_op_t  issue_op,
    input  logic [31:0] issue_rs1,
    input  logic [31:0] issue_rs2,
    input  logic [31:0] issue_pc,
    input  logic [31:0] issue_imm,
    input  logic        issue_predicted_taken,
    // resolve port
    output logic        resolve_valid,
    input  logic        resolve_ready,
    output logic        resolve_taken,
    output logic [31:0] resolve_target,
    output logic [31:0] resolve_link,
    output logic        resolve_mispredict,
    output logic [31:0] resolve_redirect_pc,
    output logic        resolve_misaligned,
    // predictor training
    output logic        update_valid,
    output logic [31:0] update_pc,
    output logic        update_taken
);

    logic        use_signed;
    logic        less_than;
    logic        xor_result;
    logic        is_jump;
    logic        compare_result;
    logic        taken;
    logic [31:0] target;
    logic [31:0] link;
    logic        misaligned;
    logic        accept;
    // resolve payload kept for the predictor only
    logic [31:0] resolve_pc;
    logic        resolve_conditional;

    ////////////////////
    // decode
    ////////////////////
    always_comb begin
        use_signed = 1'b0;
        less_than  = 1'b0;
        xor_result = 1'b0;
        is_jump    = 1'b0;
        case (issue_op)
            branch_eq:  ;
            branch_ne:  xor_result = 1'b1;
            branch_lt: begin
                use_signed = 1'b1;
                less_than  = 1'b1;
            end
            branch_ge: begin
                use_signed = 1'b1;
                less_than  = 1'b1;
                xor_result = 1'b1;
            end
            branch_ltu: less_than = 1'b1;
            branch_geu: begin
                less_than  = 1'b1;
                xor_result = 1'b1;
            end
            default:    is_jump = 1'b1;
        endcase
    end

    branch_comparator comparator (
        .use_signed (use_signed),
        .less_than  (less_than),
        .a          (issue_rs1),
        .b          (issue_rs2),
        .xor_result (xor_result),
        .result     (compare_result)
    );

    branch_target target_unit (
        .op         (issue_op),
        .pc         (issue_pc),
        .rs1        (issue_rs1),
        .imm        (issue_imm),
        .target     (target),
        .link       (link),
        .misaligned (misaligned)
    );

    // jal and jalr never fall through
    assign taken = is_jump | compare_result;

    ////////////////////
    // resolve register
    ////////////////////

    // a slot frees up when it is empty or being drained this cycle
    assign issue_ready = ~resolve_valid | resolve_ready;
    assign accept      = issue_valid & issue_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            resolve_valid <= 1'b0;
        end else if (issue_ready) begin
            resolve_valid <= issue_valid;
        end
    end

    // payload only moves on acceptance, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            resolve_taken       <= taken;
            resolve_target      <= target;
            resolve_link        <= link;
            resolve_misaligned  <= misaligned;
            resolve_mispredict  <= taken ^ issue_predicted_taken;
            // restart at the side fetch did not follow
            resolve_redirect_pc <= taken ? target : link;
            resolve_pc          <= issue_pc;
            resolve_conditional <= ~is_jump;
        end
    end

    // train on the handshake edge, jumps would only pollute the table
    assign update_valid = resolve_valid & resolve_ready & resolve_conditional;
    assign update_pc    = resolve_pc;
    assign update_taken = resolve_taken;

endmodule

//--- common/branch_pkg.sv
package branch_pkg;

    ////////////////////
    // branch operations
    ////////////////////

    // the low bits follow the riscv funct3 of the branch group
    // bit 2 picks the less-than family, bit 0 inverts the answer
    // jal and jalr sit in the two funct3 codes that no branch uses
    typedef enum logic [2:0] {
        // equal
        branch_eq  = 3'b000,
        // not equal
        branch_ne  = 3'b001,
        // jump and link, pc relative
        jump_jal   = 3'b010,
        // jump and link, register relative
        jump_jalr  = 3'b011,
        // signed less than
        branch_lt  = 3'b100,
        // signed greater or equal
        branch_ge  = 3'b101,
        // unsigned less than
        branch_ltu = 3'b110,
        // unsigned greater or equal
        branch_geu = 3'b111
    } branch_op_t;

    ////////////////////
    // predictor counters
    ////////////////////

    // two-bit saturating counter, upper bit is the prediction
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_state_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run the branch resolution testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module branch_tb -f verilog.f -o branch_sim

# keep the simulation output, the log decides the result
./obj_dir/branch_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- src/branch_predictor.sv
module branch_predictor import branch_pkg::*; #(
    // power of two, at least 2
    parameter int PREDICTOR_ENTRIES = 64
) (
    input  logic        clk,
    input  logic        rst,
    // fetch lookup
    input  logic [31:0] fetch_pc,
    output logic        fetch_predict_taken,
    // training from resolve
    input  logic        update_valid,
    input  logic [31:0] update_pc,
    input  logic        update_taken
);

    localparam int INDEX_BITS = $clog2(PREDICTOR_ENTRIES);

    counter_state_t             counters [PREDICTOR_ENTRIES];
    logic [INDEX_BITS-1:0]      fetch_index;
    logic [INDEX_BITS-1:0]      update_index;
    counter_state_t             fetch_state;
    counter_state_t             update_state;
    counter_state_t             next_state;

    ////////////////////
    // indexing
    ////////////////////

    // instructions are word aligned, so pc bits 1:0 carry no information
    assign fetch_index  = fetch_pc[INDEX_BITS+1:2];
    assign update_index = update_pc[INDEX_BITS+1:2];

    ////////////////////
    // lookup
    ////////////////////
    assign fetch_state = counters[fetch_index];

    // read straight from the table, an update this cycle lands after the edge
    assign fetch_predict_taken = (fetch_state == weak_taken) ||
                                 (fetch_state == strong_taken);

    ////////////////////
    // counter step
    ////////////////////
    assign update_state = counters[update_index];

    always_comb begin
        next_state = update_state;
        if (update_taken) begin
            case (update_state)
                strong_not_taken: next_state = weak_not_taken;
                weak_not_taken:   next_state = weak_taken;
                weak_taken:       next_state = strong_taken;
                // saturates at the top
                default:          next_state = strong_taken;
            endcase
        end else begin
            case (update_state)
                strong_taken:     next_state = weak_taken;
                weak_taken:       next_state = weak_not_taken;
                weak_not_taken:   next_state = strong_not_taken;
                // saturates at the bottom
                default:          next_state = strong_not_taken;
            endcase
        end
    end

    ////////////////////
    // table
    ////////////////////

    // the table starts weakly not taken so one taken outcome flips it
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PREDICTOR_ENTRIES; i++) begin
                counters[i] <= weak_not_taken;
            end
        end else if (update_valid) begin
            counters[update_index] <= next_state;
        end
    end

endmodule

//--- src/branch_top.sv
module branch_top import branch_pkg::*; #(
    parameter int PREDICTOR_ENTRIES = 64
) (
    input  logic        clk,
    input  logic        rst,
    // issue port
    input  logic        issue_valid,
    output logic        issue_ready,
    input  branch_op_t  issue_op,
    input  logic [31:0] issue_rs1,
    input  logic [31:0] issue_rs2,
    input  logic [31:0] issue_pc,
    input  logic [31:0] issue_imm,
    input  logic        issue_predicted_taken,
    // resolve port
    output logic        resolve_valid,
    input  logic        resolve_ready,
    output logic        resolve_taken,
    output logic [31:0] resolve_target,
    output logic [31:0] resolve_link,
    output logic        resolve_mispredict,
    output logic [31:0] resolve_redirect_pc,
    output logic        resolve_misaligned,
    // fetch lookup
    input  logic [31:0] fetch_pc,
    output logic        fetch_predict_taken
);

    // training path from resolve into the counter table
    logic        update_valid;
    logic [31:0] update_pc;
    logic        update_taken;

    branch_unit unit (
        .clk                   (clk),
        .rst                   (rst),
        .issue_valid           (issue_valid),
        .issue_ready           (issue_ready),
        .issue_op              (issue_op),
        .issue_rs1             (issue_rs1),
        .issue_rs2             (issue_rs2),
        .issue_pc              (issue_pc),
        .issue_imm             (issue_imm),
        .issue_predicted_taken (issue_predicted_taken),
        .resolve_valid         (resolve_valid),
        .resolve_ready         (resolve_ready),
        .resolve_taken         (resolve_taken),
        .resolve_target        (resolve_target),
        .resolve_link          (resolve_link),
        .resolve_mispredict    (resolve_mispredict),
        .resolve_redirect_pc   (resolve_redirect_pc),
        .resolve_misaligned    (resolve_misaligned),
        .update_valid          (update_valid),
        .update_pc             (update_pc),
        .update_taken          (update_taken)
    );

    branch_predictor #(
        .PREDICTOR_ENTRIES (PREDICTOR_ENTRIES)
    ) predictor (
        .clk                 (clk),
        .rst                 (rst),
        .fetch_pc            (fetch_pc),
        .fetch_predict_taken (fetch_predict_taken),
        .update_valid        (update_valid),
        .update_pc           (update_pc),
        .update_taken        (update_taken)
    );

endmodule

//--- verilog.f
common/branch_pkg.sv
branch_unit/branch_comparator.sv
branch_unit/branch_target.sv
branch_unit/branch_unit.sv
src/branch_predictor.sv
src/branch_top.sv
bench/branch_props.sv
bench/branch_tb.sv
